/* opn_timer_pkg.sv */
package opn_timer_pkg;

	// **************************************************
	// timer widths and prescale
	// **************************************************

	// timer A counts sample ticks over a 10-bit range.
	parameter int TIMER_A_WIDTH = 10;

	// timer B counts over 8 bits.
	parameter int TIMER_B_WIDTH = 8;

	// timer B advances once per group of 16 sample ticks.
	parameter int TIMER_B_PRESCALE = 16;

	// **************************************************
	// bus and register types
	// **************************************************

	// one byte on the host bus, either a register number or a value.
	typedef logic [7:0] bus_data_t;

	// register numbers decoded in bank 0.
	typedef enum logic [7:0] {
		REG_TIMER_A_HI = 8'h24,
		REG_TIMER_A_LO = 8'h25,
		REG_TIMER_B    = 8'h26,
		REG_TIMER_CTRL = 8'h27
	} reg_addr_e;

	// state of the address latch.
	typedef enum logic {
		ADDR_IDLE = 1'b0,
		ADDR_HELD = 1'b1
	} addr_state_e;

	// bit positions inside register 0x27.
	parameter int CTRL_RUN_A   = 0;
	parameter int CTRL_RUN_B   = 1;
	parameter int CTRL_FLAG_A  = 2;
	parameter int CTRL_FLAG_B  = 3;
	parameter int CTRL_CLEAR_A = 4;
	parameter int CTRL_CLEAR_B = 5;

endpackage

/* timer_ctrl_if.sv */
interface timer_ctrl_if #(
	parameter int A_WIDTH = 10,
	parameter int B_WIDTH = 8
);

	// reload values of the two timers.
	logic [A_WIDTH-1:0] load_a;
	logic [B_WIDTH-1:0] load_b;

	// run bits, level.
	logic run_a;
	logic run_b;

	// status flag enables, level.
	logic flag_en_a;
	logic flag_en_b;

	// one-cycle flag clears.
	logic clear_a;
	logic clear_b;

	modport reg_side (
		output load_a,
		output load_b,
		output run_a,
		output run_b,
		output flag_en_a,
		output flag_en_b,
		output clear_a,
		output clear_b
	);

	modport status_side (
		input flag_en_a,
		input flag_en_b,
		input clear_a,
		input clear_b
	);

endinterface

/* opn_reg_port.sv */
module opn_reg_port #(
	parameter int A_WIDTH = 10,
	parameter int B_WIDTH = 8
) (
	input  logic                   mclk_i,
	input  logic                   rst_i,
	input  opn_timer_pkg::bus_data_t data_i,
	input  logic                   bank_i,
	input  logic                   addr_wr_i,
	input  logic                   data_wr_i,
	timer_ctrl_if.reg_side         ctrl
);

	opn_timer_pkg::addr_state_e state_q;
	opn_timer_pkg::reg_addr_e   sel_q;

	logic addr_kept;
	logic wr_en;
	logic wr_ctrl;

	// **************************************************
	// address latch
	// **************************************************

	// only bank 0 writes to the timer registers select anything.
	always_comb begin
		case (data_i)
			opn_timer_pkg::REG_TIMER_A_HI,
			opn_timer_pkg::REG_TIMER_A_LO,
			opn_timer_pkg::REG_TIMER_B,
			opn_timer_pkg::REG_TIMER_CTRL: addr_kept = !bank_i;
			default: addr_kept = 1'b0;
		endcase
	end

	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			state_q <= opn_timer_pkg::ADDR_IDLE;
			sel_q   <= opn_timer_pkg::REG_TIMER_A_HI;
		end else if (addr_wr_i) begin
			if (addr_kept) begin
				state_q <= opn_timer_pkg::ADDR_HELD;
				sel_q   <= opn_timer_pkg::reg_addr_e'(data_i);
			end else begin
				state_q <= opn_timer_pkg::ADDR_IDLE;
			end
		end
	end

	// the selection stays until the next address write, so a data write
	// in the same cycle as an address write still uses the old one.
	assign wr_en   = data_wr_i && (state_q == opn_timer_pkg::ADDR_HELD);
	assign wr_ctrl = wr_en && (sel_q == opn_timer_pkg::REG_TIMER_CTRL);

	// **************************************************
	// timer registers
	// **************************************************

	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			ctrl.load_a    <= '0;
			ctrl.load_b    <= '0;
			ctrl.run_a     <= 1'b0;
			ctrl.run_b     <= 1'b0;
			ctrl.flag_en_a <= 1'b0;
			ctrl.flag_en_b <= 1'b0;
		end else if (wr_en) begin
			case (sel_q)
				opn_timer_pkg::REG_TIMER_A_HI: begin
					ctrl.load_a[A_WIDTH-1 -: 8] <= data_i;
				end
				opn_timer_pkg::REG_TIMER_A_LO: begin
					ctrl.load_a[A_WIDTH-9:0] <= data_i[A_WIDTH-9:0];
				end
				opn_timer_pkg::REG_TIMER_B: begin
					ctrl.load_b <= data_i[B_WIDTH-1:0];
				end
				opn_timer_pkg::REG_TIMER_CTRL: begin
					ctrl.run_a     <= data_i[opn_timer_pkg::CTRL_RUN_A];
					ctrl.run_b     <= data_i[opn_timer_pkg::CTRL_RUN_B];
					ctrl.flag_en_a <= data_i[opn_timer_pkg::CTRL_FLAG_A];
					ctrl.flag_en_b <= data_i[opn_timer_pkg::CTRL_FLAG_B];
				end
				default: begin
					ctrl.run_a <= ctrl.run_a;
				end
			endcase
		end
	end

	// clear bits are not stored.
	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			ctrl.clear_a <= 1'b0;
			ctrl.clear_b <= 1'b0;
		end else begin
			ctrl.clear_a <= wr_ctrl && data_i[opn_timer_pkg::CTRL_CLEAR_A];
			ctrl.clear_b <= wr_ctrl && data_i[opn_timer_pkg::CTRL_CLEAR_B];
		end
	end

	// a clear reaches the status flags as a single-cycle pulse.
	clear_a_pulse: assert property (@(posedge mclk_i) disable iff (rst_i)
		ctrl.clear_a |=> !ctrl.clear_a);

	clear_b_pulse: assert property (@(posedge mclk_i) disable iff (rst_i)
		ctrl.clear_b |=> !ctrl.clear_b);

endmodule

/* opn_timer.sv */
module opn_timer #(
	parameter int WIDTH    = 10,
	parameter int PRESCALE = 1
) (
	input  logic             mclk_i,
	input  logic             rst_i,
	input  logic             tick_i,
	input  logic             run_i,
	input  logic [WIDTH-1:0] load_val_i,
	output logic             ovf_o
);

	localparam int PS_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

	logic [PS_W-1:0]  pre_cnt_q;
	logic             pre_wrap;
	logic             cnt_tick;
	logic             run_q;
	logic [WIDTH-1:0] cnt_q;
	logic             at_top;

	// **************************************************
	// tick prescaler
	// **************************************************

	// free running from reset, independent of the run bit.
	assign pre_wrap = (pre_cnt_q == PS_W'(PRESCALE - 1));
	assign cnt_tick = tick_i && pre_wrap;

	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			pre_cnt_q <= '0;
		end else if (tick_i) begin
			if (pre_wrap) begin
				pre_cnt_q <= '0;
			end else begin
				pre_cnt_q <= pre_cnt_q + 1'b1;
			end
		end
	end

	// **************************************************
	// reload counter
	// **************************************************

	assign at_top = &cnt_q;

	// run_q low with run_i high marks the load cycle.
	assign ovf_o = run_i && run_q && cnt_tick && at_top;

	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			run_q <= 1'b0;
			cnt_q <= '0;
		end else begin
			run_q <= run_i;
			if (run_i && !run_q) begin
				cnt_q <= load_val_i;
			end else if (run_i && cnt_tick) begin
				// a new reload value is picked up here
				if (at_top) begin
					cnt_q <= load_val_i;
				end else begin
					cnt_q <= cnt_q + 1'b1;
				end
			end
		end
	end

	// an overflow needs the timer to have run through the previous cycle,
	// so none can come in the load cycle.
	ovf_when_running: assert property (@(posedge mclk_i) disable iff (rst_i)
		ovf_o |-> run_i && $past(run_i));

endmodule

/* opn_status.sv */
module opn_status (
	input  logic                  mclk_i,
	input  logic                  rst_i,
	input  logic                  ovf_a_i,
	input  logic                  ovf_b_i,
	timer_ctrl_if.status_side     ctrl,
	output logic [1:0]            status_o,
	output logic                  irq_o
);

	logic [1:0] flag_q;
	logic [1:0] ovf;
	logic [1:0] enable;
	logic [1:0] clear;

	// bit 0 is timer A, bit 1 is timer B.
	assign ovf    = {ovf_b_i, ovf_a_i};
	assign enable = {ctrl.flag_en_b, ctrl.flag_en_a};
	assign clear  = {ctrl.clear_b, ctrl.clear_a};

	// **************************************************
	// status flags
	// **************************************************

	// a clear wins over a set in the same cycle.
	always_ff @(posedge mclk_i) begin
		if (rst_i) begin
			flag_q <= 2'b00;
		end else begin
			flag_q <= (flag_q | (ovf & enable)) & ~clear;
		end
	end

	assign status_o = flag_q;
	assign irq_o    = |flag_q;

	// the enable comes from the register port, so a flag may only rise
	// when the enable was already set at the overflow.
	flag_a_enabled: assert property (@(posedge mclk_i) disable iff (rst_i)
		$rose(status_o[0]) |-> $past(ctrl.flag_en_a));

	flag_b_enabled: assert property (@(posedge mclk_i) disable iff (rst_i)
		$rose(status_o[1]) |-> $past(ctrl.flag_en_b));

endmodule

/* opn_timer_top.sv */
module opn_timer_top #(
	parameter int TIMER_A_WIDTH    = opn_timer_pkg::TIMER_A_WIDTH,
	parameter int TIMER_B_WIDTH    = opn_timer_pkg::TIMER_B_WIDTH,
	parameter int TIMER_B_PRESCALE = opn_timer_pkg::TIMER_B_PRESCALE
) (
	input  logic                     mclk_i,
	input  logic                     rst_i,
	input  logic                     tick_i,
	input  opn_timer_pkg::bus_data_t data_i,
	input  logic                     bank_i,
	input  logic                     addr_wr_i,
	input  logic                     data_wr_i,
	output logic [1:0]               status_o,
	output logic                     irq_o
);

	logic ovf_a;
	logic ovf_b;

	timer_ctrl_if #(
		.A_WIDTH(TIMER_A_WIDTH),
		.B_WIDTH(TIMER_B_WIDTH)
	) ctrl_if ();

	// **************************************************
	// host register port
	// **************************************************

	opn_reg_port #(
		.A_WIDTH(TIMER_A_WIDTH),
		.B_WIDTH(TIMER_B_WIDTH)
	) u_reg_port (
		.mclk_i   (mclk_i),
		.rst_i    (rst_i),
		.data_i   (data_i),
		.bank_i   (bank_i),
		.addr_wr_i(addr_wr_i),
		.data_wr_i(data_wr_i),
		.ctrl     (ctrl_if.reg_side)
	);

	// **************************************************
	// timers
	// **************************************************

	// timer A counts every sample tick.
	opn_timer #(
		.WIDTH   (TIMER_A_WIDTH),
		.PRESCALE(1)
	) u_timer_a (
		.mclk_i    (mclk_i),
		.rst_i     (rst_i),
		.tick_i    (tick_i),
		.run_i     (ctrl_if.run_a),
		.load_val_i(ctrl_if.load_a),
		.ovf_o     (ovf_a)
	);

	opn_timer #(
		.WIDTH   (TIMER_B_WIDTH),
		.PRESCALE(TIMER_B_PRESCALE)
	) u_timer_b (
		.mclk_i    (mclk_i),
		.rst_i     (rst_i),
		.tick_i    (tick_i),
		.run_i     (ctrl_if.run_b),
		.load_val_i(ctrl_if.load_b),
		.ovf_o     (ovf_b)
	);

	opn_status u_status (
		.mclk_i  (mclk_i),
		.rst_i   (rst_i),
		.ovf_a_i (ovf_a),
		.ovf_b_i (ovf_b),
		.ctrl    (ctrl_if.status_side),
		.status_o(status_o),
		.irq_o   (irq_o)
	);

endmodule

/* tb_opn_timer_tests.svh */
	// **************************************************
	// wait loops
	// **************************************************

	// ticks until status_o reaches exp, ticks is -1 on a timeout.
	task automatic tick_until_status(input logic [1:0] exp, input int limit, output int ticks);
		ticks = 0;
		while (status !== exp && ticks < limit) begin
			tick_once();
			ticks++;
		end
		if (status !== exp) begin
			$display("timeout: status_o did not reach 0x%h within %0d ticks", exp, limit);
			error_count++;
			ticks = -1;
		end
	endtask

	task automatic wait_status(input logic [1:0] exp, input int limit);
		int n;
		n = 0;
		while (status !== exp && n < limit) begin
			@(negedge mclk);
			n++;
		end
		if (status !== exp) begin
			$display("timeout: status_o did not reach 0x%h within %0d cycles", exp, limit);
			error_count++;
		end
	endtask

	// runs n ticks and stops early if any flag shows up.
	task automatic tick_quiet(input int n, input string what);
		int i;
		i = 0;
		while (i < n && status === 2'b00 && irq === 1'b0) begin
			tick_once();
			i++;
		end
		check_status(2'b00, what);
		check_irq(1'b0, what);
	endtask

	// **************************************************
	// directed tests
	// **************************************************

	task automatic test_reset_state();
		check_status(2'b00, "after reset");
		check_irq(1'b0, "after reset");
		tick_quiet(2000, "idle after reset");
	endtask

	task automatic test_timer_a();
		logic [31:0] rnd;
		logic [9:0]  n;
		int          ticks;
		rnd = $random(seed);
		n   = rnd[9:0];
		write_reg(opn_timer_pkg::REG_TIMER_A_HI, n[9:2], 1'b0);
		write_reg(opn_timer_pkg::REG_TIMER_A_LO, {6'b000000, n[1:0]}, 1'b0);
		write_reg(opn_timer_pkg::REG_TIMER_CTRL, 8'h05, 1'b0);
		// the cycle after run rises is the load cycle, so no tick there.
		idle_cycles(1);
		tick_until_status(2'b01, 1100, ticks);
		if (ticks >= 0) begin
			check_ticks(ticks, 1024 - n, 1024 - n, "timer A period");
		end
		check_irq(1'b1, "timer A flag");
		write_reg(opn_timer_pkg::REG_TIMER_CTRL, 8'h10, 1'b0);
		wait_status(2'b00, 8);
		check_irq(1'b0, "timer A stopped and cleared");
	endtask

	task automatic test_timer_b();
		int ticks;
		write_reg(opn_timer_pkg::REG_TIMER_B, 8'hFC, 1'b0);
		write_reg(opn_timer_pkg::REG_TIMER_CTRL, 8'h0A, 1'b0);
		idle_cycles(1);
		tick_until_status(2'b10, 100, ticks);
		// the prescaler phase is free, so the first period may be short.
		if (ticks >= 0) begin
			check_ticks(ticks, 16 * 4 - 15, 16 * 4, "timer B period");
		end
		check_irq(1'b1, "timer B flag");
		write_reg(opn_timer_pkg::REG_TIMER_CTRL, 8'h30, 1'b0);
		wait_status(2'b00, 8);
	endtask

	task automatic test_flag_clear();
		int ticks;
		// both timers overflow every 16 ticks with these loads.
		write_reg(opn_timer_pkg::REG_TIMER_A_HI, 8'hFC, 1'b0);
		write_reg(opn_timer_pkg::REG_TIMER_A_LO, 8'h00, 1'b0);
		write_reg(opn_timer_pkg::REG_TIMER_B, 8'hFF, 1'b0);
		write_reg(opn_timer_pkg::REG_TIMER_CTRL, 8'h0F, 1'b0);
		idle_cycles(1);
		tick_until_status(2'b11, 40, ticks);
		check_irq(1'b1, "both flags set");

		write_reg(opn_timer_pkg::REG_TIMER_CTRL, 8'h1F, 1'b0);
		wait_status(2'b10, 8);
		check_status(2'b10, "clear of flag A");
		check_irq(1'b1, "clear of flag A");

		tick_until_status(2'b11, 40, ticks);
		write_reg(opn_timer_pkg::REG_TIMER_CTRL, 8'h2F, 1'b0);
		wait_status(2'b01, 8);
		check_status(2'b01, "clear of flag B");
		check_irq(1'b1, "clear of flag B");

		// Timers keep running with both flag enables off.
		write_reg(opn_timer_pkg::REG_TIMER_CTRL, 8'h33, 1'b0);
		wait_status(2'b00, 8);
		ovf_a_seen = 0;
		ovf_b_seen = 0;
		tick_quiet(200, "flags disabled");
		if (ovf_a_seen == 0) begin
			$display("timer A did not overflow while its flag was disabled");
			error_count++;
		end
		if (ovf_b_seen == 0) begin
			$display("timer B did not overflow while its flag was disabled");
			error_count++;
		end
		write_reg(opn_timer_pkg::REG_TIMER_CTRL, 8'h00, 1'b0);
	endtask

	task automatic test_bus_rule();
		int ticks;
		// the last address write named 0x27, a bank 1 address must drop it.
		write_reg(opn_timer_pkg::REG_TIMER_CTRL, 8'h0F, 1'b1);
		idle_cycles(1);
		tick_quiet(2000, "write after a bank 1 address");
		write_reg(8'h20, 8'h0F, 1'b0);
		idle_cycles(1);
		tick_quiet(2000, "write after address 0x20");
		// a proper write still starts timer A.
		write_reg(opn_timer_pkg::REG_TIMER_CTRL, 8'h05, 1'b0);
		idle_cycles(1);
		tick_until_status(2'b01, 40, ticks);
		write_reg(opn_timer_pkg::REG_TIMER_CTRL, 8'h30, 1'b0);
		wait_status(2'b00, 8);
	endtask

/* tb_opn_timer.sv */
module tb_opn_timer;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 5;

	logic                     mclk;
	logic                     rst;
	logic                     tick;
	opn_timer_pkg::bus_data_t data;
	logic                     bank;
	logic                     addr_wr;
	logic                     data_wr;
	logic [1:0]               status;
	logic                     irq;

	int     error_count;
	int     check_count;
	integer seed;
	int     ovf_a_seen;
	int     ovf_b_seen;

	opn_timer_top #(
		.TIMER_A_WIDTH   (opn_timer_pkg::TIMER_A_WIDTH),
		.TIMER_B_WIDTH   (opn_timer_pkg::TIMER_B_WIDTH),
		.TIMER_B_PRESCALE(opn_timer_pkg::TIMER_B_PRESCALE)
	) DUT (
		.mclk_i   (mclk),
		.rst_i    (rst),
		.tick_i   (tick),
		.data_i   (data),
		.bank_i   (bank),
		.addr_wr_i(addr_wr),
		.data_wr_i(data_wr),
		.status_o (status),
		.irq_o    (irq)
	);

	initial begin
		mclk = 1'b0;
		forever #(CLK_PERIOD / 2) mclk = ~mclk;
	end

	// **************************************************
	// bus, tick and reset drivers
	// **************************************************

	// every driver starts and ends on a falling edge.
	task automatic idle_cycles(input int n);
		repeat (n) @(negedge mclk);
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge mclk);
		rst = 1'b0;
	endtask

	task automatic addr_write(input opn_timer_pkg::bus_data_t addr, input logic bank_sel);
		data    = addr;
		bank    = bank_sel;
		addr_wr = 1'b1;
		@(negedge mclk);
		addr_wr = 1'b0;
		bank    = 1'b0;
	endtask

	task automatic data_write(input opn_timer_pkg::bus_data_t value);
		data    = value;
		data_wr = 1'b1;
		@(negedge mclk);
		data_wr = 1'b0;
	endtask

	task automatic write_reg(input opn_timer_pkg::bus_data_t addr,
			input opn_timer_pkg::bus_data_t value, input logic bank_sel);
		addr_write(addr, bank_sel);
		data_write(value);
	endtask

	// one sample tick, high for one cycle out of four.
	// the overflow pulses are looked at in the middle of the tick cycle.
	task automatic tick_once();
		tick = 1'b1;
		#(CLK_PERIOD / 4);
		if (DUT.ovf_a) begin
			ovf_a_seen++;
		end
		if (DUT.ovf_b) begin
			ovf_b_seen++;
		end
		@(negedge mclk);
		tick = 1'b0;
		repeat (3) @(negedge mclk);
	endtask

	// **************************************************
	// compare tasks
	// **************************************************

	task automatic check_status(input logic [1:0] exp, input string what);
		check_count++;
		if (status !== exp) begin
			$display("** Error: status_o = 0x%h, expected 0x%h (%s)", status, exp, what);
			error_count++;
		end
	endtask

	task automatic check_irq(input logic exp, input string what);
		check_count++;
		if (irq !== exp) begin
			$display("** Error: irq_o = 0x%h, expected 0x%h (%s)", irq, exp, what);
			error_count++;
		end
	endtask

	task automatic check_ticks(input int got, input int lo, input int hi, input string what);
		check_count++;
		if (got < lo || got > hi) begin
			$display("** Error: ticks to flag = 0x%0h, expected 0x%0h to 0x%0h (%s)",
				got, lo, hi, what);
			error_count++;
		end
	endtask

	`include "tb_opn_timer_tests.svh"

	initial begin
		error_count = 0;
		check_count = 0;
		ovf_a_seen  = 0;
		ovf_b_seen  = 0;
		seed        = 32'h2c6b;
		rst         = 1'b1;
		tick        = 1'b0;
		data        = '0;
		bank        = 1'b0;
		addr_wr     = 1'b0;
		data_wr     = 1'b0;

		apply_reset();
		test_reset_state();
		test_timer_a();
		test_timer_b();
		test_flag_clear();
		test_bus_rule();

		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* project.f */
+incdir+.
opn_timer_pkg.sv
timer_ctrl_if.sv
opn_reg_port.sv
opn_timer.sv
opn_status.sv
opn_timer_top.sv
tb_opn_timer.sv

/* run.sh */
#!/bin/sh
# Builds the timer testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f project.f \
	--top-module tb_opn_timer \
	-o tb_opn_timer_sim

./obj_dir/tb_opn_timer_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
